// File: sim.f
+incdir+tb
hdl/mips_pkg.sv
hdl/mips_decoder.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_fetch.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, and decide on the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mips_core -o tb_mips_core \
    && { ./obj_dir/tb_mips_core > sim.log 2>&1; cat sim.log; true; } \
    && grep -q "ALL CHECKS PASSED" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// File: tb/mips_ref_model.svh
localparam int MEM_WORDS    = 256;
localparam int DIRECTED_LEN = 22;
localparam int RANDOM_LEN   = 200;

// memories seen by the dut
mips_pkg::word_t imem [MEM_WORDS];
mips_pkg::word_t dmem [MEM_WORDS];
// architectural state of the model
mips_pkg::word_t ref_dmem [MEM_WORDS];
mips_pkg::word_t ref_regs [32];
mips_pkg::word_t ref_pc;
mips_pkg::word_t halt_pc;
int prog_len;
int seed;

function automatic mips_pkg::word_t enc_r(input mips_pkg::reg_addr_t rs,
        input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rd,
        input mips_pkg::funct_t fn);
    return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_t op,
        input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// target given as a word index
function automatic mips_pkg::word_t enc_j(input mips_pkg::opcode_t op, input int index);
    return {op, 26'(index)};
endfunction

function automatic int rand_below(input int n);
    int unsigned v;
    v = $random(seed);
    return int'(v % n);
endfunction

function automatic mips_pkg::reg_addr_t rand_reg();
    return 5'(1 + rand_below(15));
endfunction

task automatic emit(input mips_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
endtask

function automatic void record_write(inout mips_pkg::wb_trace_t t,
        input mips_pkg::reg_addr_t r, input mips_pkg::word_t v);
    // $zero never shows up on the trace
    if (r != 5'd0) begin
        t.valid = 1'b1;
        t.addr = r;
        t.data = v;
        ref_regs[r] = v;
    end
endfunction

// ====================
// one instruction at ref_pc
// ====================
function automatic void ref_step(output mips_pkg::wb_trace_t exp_wb,
        output mips_pkg::dmem_req_t exp_mem, output mips_pkg::word_t next_pc);
    mips_pkg::word_t ir;
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t imm;
    mips_pkg::word_t seq_pc;
    mips_pkg::word_t ea;
    ir = imem[ref_pc[9:2]];
    a = ref_regs[ir[25:21]];
    b = ref_regs[ir[20:16]];
    imm = {{16{ir[15]}}, ir[15:0]};
    seq_pc = ref_pc + 32'd4;
    ea = a + imm;
    exp_wb = '0;
    exp_mem = '0;
    next_pc = seq_pc;
    case (ir[31:26])
        mips_pkg::OP_RTYPE: begin
            case (ir[5:0])
                mips_pkg::FN_ADD: record_write(exp_wb, ir[15:11], a + b);
                mips_pkg::FN_SUB: record_write(exp_wb, ir[15:11], a - b);
                mips_pkg::FN_AND: record_write(exp_wb, ir[15:11], a & b);
                mips_pkg::FN_OR:  record_write(exp_wb, ir[15:11], a | b);
                mips_pkg::FN_SLT: record_write(exp_wb, ir[15:11], {31'd0, $signed(a) < $signed(b)});
                mips_pkg::FN_JR:  next_pc = a;
                default: ;
            endcase
        end
        mips_pkg::OP_ADDI: record_write(exp_wb, ir[20:16], ea);
        mips_pkg::OP_LW: begin
            exp_mem.addr = ea;
            exp_mem.re = 1'b1;
            record_write(exp_wb, ir[20:16], ref_dmem[ea[9:2]]);
        end
        mips_pkg::OP_SW: begin
            exp_mem = '{addr: ea, wdata: b, re: 1'b0, we: 1'b1};
            ref_dmem[ea[9:2]] = b;
        end
        mips_pkg::OP_BEQ: if (a == b) next_pc = seq_pc + {imm[29:0], 2'b00};
        mips_pkg::OP_J:   next_pc = {seq_pc[31:28], ir[25:0], 2'b00};
        mips_pkg::OP_JAL: begin
            record_write(exp_wb, mips_pkg::LINK_REG, seq_pc);
            next_pc = {seq_pc[31:28], ir[25:0], 2'b00};
        end
        default: ;
    endcase
endfunction

// ====================
// program of a directed part and a random part closed by a jump to itself
// ====================
task automatic build_program();
    int kind;
    int off;
    mips_pkg::reg_addr_t ra;
    mips_pkg::reg_addr_t rb;
    mips_pkg::funct_t fn;
    prog_len = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
        // unused slots hold undefined opcodes tagged with their address
        imem[i] = {6'h3f, 26'(i * 4)};
        dmem[i] = 32'hda7a0000 + 32'(i * 4);
        ref_dmem[i] = dmem[i];
    end
    emit(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'd5));
    emit(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd2, 16'hfffd));
    emit(enc_r(5'd1, 5'd2, 5'd3, mips_pkg::FN_ADD));
    emit(enc_r(5'd2, 5'd1, 5'd4, mips_pkg::FN_SUB));
    emit(enc_r(5'd1, 5'd2, 5'd5, mips_pkg::FN_AND));
    emit(enc_r(5'd1, 5'd2, 5'd6, mips_pkg::FN_OR));
    emit(enc_r(5'd2, 5'd1, 5'd7, mips_pkg::FN_SLT));
    emit(enc_r(5'd1, 5'd2, 5'd8, mips_pkg::FN_SLT));
    emit(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd7));
    emit(enc_r(5'd0, 5'd1, 5'd9, mips_pkg::FN_ADD));
    // store and load at 5 + 3
    emit(enc_i(mips_pkg::OP_SW, 5'd1, 5'd4, 16'd3));
    emit(enc_i(mips_pkg::OP_LW, 5'd1, 5'd10, 16'd3));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd9, 16'd1));
    emit(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd11, 16'h0111));
    emit(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
    emit(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd12, 16'h0222));
    emit(enc_j(mips_pkg::OP_J, 18));
    emit(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd13, 16'h0333));
    emit(enc_j(mips_pkg::OP_JAL, 21));
    emit({6'h3f, 26'd0});
    emit(enc_j(mips_pkg::OP_J, DIRECTED_LEN));
    emit(enc_r(mips_pkg::LINK_REG, 5'd0, 5'd0, mips_pkg::FN_JR));
    for (int i = 0; i < RANDOM_LEN; i++) begin
        kind = rand_below(8);
        ra = rand_reg();
        rb = rand_reg();
        if (kind < 5) begin
            case (kind)
                0: fn = mips_pkg::FN_ADD;
                1: fn = mips_pkg::FN_SUB;
                2: fn = mips_pkg::FN_AND;
                3: fn = mips_pkg::FN_OR;
                default: fn = mips_pkg::FN_SLT;
            endcase
            emit(enc_r(ra, rb, rand_reg(), fn));
        end else if (kind == 5) begin
            emit(enc_i(mips_pkg::OP_ADDI, ra, rb, 16'(rand_below(65536))));
        end else if (kind == 6) begin
            emit(enc_i(rand_below(2) == 0 ? mips_pkg::OP_LW : mips_pkg::OP_SW,
                5'd0, rb, 16'(rand_below(64) * 4)));
        end else begin
            // forward only and never past the final jump
            off = rand_below(4);
            if (prog_len + 1 + off > DIRECTED_LEN + RANDOM_LEN) begin
                off = DIRECTED_LEN + RANDOM_LEN - prog_len - 1;
            end
            if (rand_below(2) == 0) begin
                rb = ra;
            end
            emit(enc_i(mips_pkg::OP_BEQ, ra, rb, 16'(off)));
        end
    end
    halt_pc = 32'(prog_len * 4);
    emit(enc_j(mips_pkg::OP_J, prog_len));
    ref_pc = mips_pkg::RESET_PC;
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
endtask

// File: tb/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    logic                clk;
    logic                rst_n;
    mips_pkg::word_t     imem_addr;
    mips_pkg::word_t     instr;
    mips_pkg::dmem_req_t dmem_req;
    mips_pkg::word_t     dmem_rdata;
    mips_pkg::wb_trace_t wb;
    logic                prog_ready;

    `include "mips_ref_model.svh"

    mips_core dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ====================
    // checks
    // ====================
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_wb(input mips_pkg::wb_trace_t exp, input mips_pkg::wb_trace_t act);
        if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
            $display("Error: wb expected %h actual %h at pc %h", exp, act, ref_pc);
            abort_run();
        end
    endtask

    task automatic check_dmem(input mips_pkg::dmem_req_t exp, input mips_pkg::dmem_req_t act);
        if (act.we !== exp.we || act.re !== exp.re || (exp.we && act !== exp)) begin
            $display("Error: dmem_req expected %h actual %h at pc %h", exp, act, ref_pc);
            abort_run();
        end
    endtask

    task automatic check_pc(input mips_pkg::word_t exp, input mips_pkg::word_t act);
        if (act !== exp) begin
            $display("Error: imem_addr expected %h actual %h", exp, act);
            abort_run();
        end
    endtask

    initial begin
        rst_n = 1'b1;
        instr = '0;
        dmem_rdata = '0;
        prog_ready = 1'b0;
        seed = 68;
        build_program();
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
    end

    // memory reads with the data read once the address has settled
    always @(negedge clk) begin
        instr = imem[imem_addr[9:2]];
        #1;
        dmem_rdata = dmem[dmem_req.addr[9:2]];
    end

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    // ====================
    // compare against the model
    // ====================
    initial begin : compare
        mips_pkg::wb_trace_t exp_wb;
        mips_pkg::dmem_req_t exp_mem;
        mips_pkg::word_t     next_pc;
        @(negedge clk);
        #10;
        while (rst_n) begin
            check_pc(mips_pkg::RESET_PC, imem_addr);
            check_dmem('0, dmem_req);
            check_wb('0, wb);
            @(negedge clk);
            #10;
        end
        while (ref_pc != halt_pc) begin
            check_pc(ref_pc, imem_addr);
            ref_step(exp_wb, exp_mem, next_pc);
            check_wb(exp_wb, wb);
            check_dmem(exp_mem, dmem_req);
            ref_pc = next_pc;
            @(negedge clk);
            #10;
        end
        check_pc(halt_pc, imem_addr);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (prog_ready);
        #((prog_len + 10) * 200);
        $display("timeout, the program never reached its final jump");
        abort_run();
    end

endmodule

`default_nettype wire

// File: hdl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire                  clk,
    input  wire                  rst_n,
    output mips_pkg::word_t      imem_addr,
    input  wire mips_pkg::word_t instr,
    output mips_pkg::dmem_req_t  dmem_req,
    input  wire mips_pkg::word_t dmem_rdata,
    output mips_pkg::wb_trace_t  wb
);

    // instruction fields
    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     imm_ext;

    mips_pkg::ctrl_t     ctrl;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     alu_b;
    mips_pkg::word_t     alu_result;
    logic                alu_zero;
    mips_pkg::word_t     pc;
    mips_pkg::word_t     pc_plus4;
    mips_pkg::reg_addr_t waddr;
    mips_pkg::word_t     wdata;

    // ====================
    // decode
    // ====================
    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    mips_decoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (ctrl.reg_write),
        .waddr   (waddr),
        .wdata   (wdata),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

    // ====================
    // execute
    // ====================
    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

    mips_alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .alu_zero (alu_zero),
        .rs_data  (rs_data),
        .instr    (instr),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    assign imem_addr = pc;

    // ====================
    // writeback and memory
    // ====================
    always_comb begin
        if (ctrl.link) begin
            waddr = mips_pkg::LINK_REG;
        end else begin
            waddr = ctrl.reg_dst ? rd : rt;
        end

        if (ctrl.mem_to_reg) begin
            wdata = dmem_rdata;
        end else begin
            wdata = ctrl.link ? pc_plus4 : alu_result;
        end
    end

    // strobes held low while in reset
    always_comb begin
        dmem_req.addr  = alu_result;
        dmem_req.wdata = rt_data;
        dmem_req.re    = ctrl.mem_read && !rst_n;
        dmem_req.we    = ctrl.mem_write && !rst_n;

        wb.valid = ctrl.reg_write && (waddr != '0) && !rst_n;
        wb.addr  = waddr;
        wb.data  = wdata;
    end

endmodule

`default_nettype wire

// File: hdl/mips_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mips_pkg::ctrl_t ctrl,
    input  wire                  alu_zero,
    input  wire mips_pkg::word_t rs_data,
    input  wire mips_pkg::word_t instr,
    output mips_pkg::word_t      pc,
    output mips_pkg::word_t      pc_plus4
);

    mips_pkg::word_t branch_off;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    mips_pkg::word_t next_pc;

    // ====================
    // target generation
    // ====================
    assign pc_plus4 = pc + 32'd4;

    // imm16 sign-extended, word offset to byte offset
    assign branch_off    = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign branch_target = pc_plus4 + branch_off;

    // pseudo-direct, region taken from pc+4
    assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

    // jr first, then j/jal, then taken beq
    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (ctrl.branch && alu_zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // ====================
    // pc register
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= mips_pkg::RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (rst_n) pc[1:0] == 2'b00
    ) else $error("fetch: misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: hdl/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  wire mips_pkg::alu_op_t op,
    input  wire mips_pkg::word_t   a,
    input  wire mips_pkg::word_t   b,
    output mips_pkg::word_t        result,
    output logic                   zero
);

    // ====================
    // operation select
    // ====================
    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            // signed compare, negatives sort low
            mips_pkg::ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // beq takes this from the subtraction
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      we,
    input  wire mips_pkg::reg_addr_t waddr,
    input  wire mips_pkg::word_t     wdata,
    input  wire mips_pkg::reg_addr_t raddr_a,
    input  wire mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t          rdata_a,
    output mips_pkg::word_t          rdata_b
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // $zero never takes a write
            regs[waddr] <= wdata;
        end
    end

    // ====================
    // read ports
    // ====================
    // combinational in the same cycle as decode
    always_comb begin
        rdata_a = regs[raddr_a];
        rdata_b = regs[raddr_b];
    end

    // reset clears $zero and the write guard keeps it there
    a_zero_reg : assert property (
        @(posedge clk) disable iff (rst_n) (raddr_a == '0) |-> (rdata_a == '0)
    ) else $error("regfile: register 0 read back %h", rdata_a);

endmodule

`default_nettype wire

// File: hdl/mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
    input  wire mips_pkg::opcode_t opcode,
    input  wire mips_pkg::funct_t  funct,
    output mips_pkg::ctrl_t        ctrl
);

    // ====================
    // main decode and alu control
    // ====================
    always_comb begin
        // anything not matched below is a no-op
        ctrl        = '0;
        ctrl.alu_op = mips_pkg::ALU_ADD;

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                case (funct)
                    mips_pkg::FN_ADD: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_ADD;
                    end
                    mips_pkg::FN_SUB: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_SUB;
                    end
                    mips_pkg::FN_AND: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_AND;
                    end
                    mips_pkg::FN_OR: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_OR;
                    end
                    mips_pkg::FN_SLT: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_SLT;
                    end
                    // jump to rs, no register write
                    mips_pkg::FN_JR: begin
                        ctrl.jump_reg = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            mips_pkg::OP_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // compare by subtraction, fetch looks at zero
            mips_pkg::OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J: begin
                ctrl.jump = 1'b1;
            end
            mips_pkg::OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // no instruction both loads and stores
    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("decoder: mem_read and mem_write both set, opcode %h", opcode);
    end

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // ====================
    // widths and types
    // ====================
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // data word or byte address
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;

    // ====================
    // encodings
    // ====================
    // primary opcodes, instr[31:26]
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // r-type function codes, instr[5:0]
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam word_t     RESET_PC = '0;
    // jal return address register
    localparam reg_addr_t LINK_REG = 5'd31;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // ====================
    // bundles
    // ====================
    typedef struct packed {
        logic    reg_dst;
        logic    alu_src;
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    link;
        logic    jump_reg;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  re;
        logic  we;
    } dmem_req_t;

    // one register write per retired instruction
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_trace_t;

endpackage

`default_nettype wire
